//--- design/ex_cfg.svh
// Execute stage widths
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path and register file
`define XLEN        64
`define WORD_W      32
`define REG_ADDR_W  5
`define INST_W      32

// bit positions inside cmp_flags
`define CMP_EQ      0
`define CMP_LT      1
`define CMP_LTU     2
`define CMP_W       3

`define PC_STEP     4

`endif

//--- design/ex_pkg.sv
// Execute stage types
`default_nettype none

package ex_pkg;

  typedef enum logic [3:0] {
    ALU_ADD      = 4'd0,
    ALU_SUB      = 4'd1,
    ALU_SLL      = 4'd2,
    ALU_SLT      = 4'd3,
    ALU_SLTU     = 4'd4,
    ALU_XOR      = 4'd5,
    ALU_SRL      = 4'd6,
    ALU_SRA      = 4'd7,
    ALU_OR       = 4'd8,
    ALU_AND      = 4'd9,
    ALU_LUI_PASS = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    BJ_NONE = 4'd0,
    BJ_BEQ  = 4'd1,
    BJ_BNE  = 4'd2,
    BJ_BLT  = 4'd3,
    BJ_BGE  = 4'd4,
    BJ_BLTU = 4'd5,
    BJ_BGEU = 4'd6,
    BJ_JAL  = 4'd7,
    BJ_JALR = 4'd8
  } bj_op_e;

  // access size, only carried to the memory stage
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6,
    MEM_DU = 3'd7
  } mem_kind_e;

endpackage

`default_nettype wire

//--- design/ex_forward.sv
// Operand bypass network
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_forward (
  input  wire [`REG_ADDR_W-1:0] rs1_addr,
  input  wire [`REG_ADDR_W-1:0] rs2_addr,
  input  wire [`XLEN-1:0]       rs1_data,
  input  wire [`XLEN-1:0]       rs2_data,
  input  wire [`XLEN-1:0]       imm,
  input  wire                   op2_is_imm,
  input  wire                   ex_fwd_ena,
  input  wire [`REG_ADDR_W-1:0] ex_fwd_addr,
  input  wire [`XLEN-1:0]       ex_fwd_data,
  input  wire                   ex_fwd_is_load,
  input  wire                   wb_rd_ena,
  input  wire [`REG_ADDR_W-1:0] wb_rd_addr,
  input  wire [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]      op1,
  output logic [`XLEN-1:0]      op2,
  output logic [`XLEN-1:0]      store_data,
  output logic                  load_use_stall
);

  logic              rs1_hit_ex;
  logic              rs2_hit_ex;
  logic              rs1_hit_wb;
  logic              rs2_hit_wb;
  logic [`XLEN-1:0]  rs1_val;
  logic [`XLEN-1:0]  rs2_val;

  // x0 never matches a producer
  assign rs1_hit_ex = ex_fwd_ena && (rs1_addr != '0) && (ex_fwd_addr == rs1_addr);
  assign rs2_hit_ex = ex_fwd_ena && (rs2_addr != '0) && (ex_fwd_addr == rs2_addr);
  assign rs1_hit_wb = wb_rd_ena && (rs1_addr != '0) && (wb_rd_addr == rs1_addr);
  assign rs2_hit_wb = wb_rd_ena && (rs2_addr != '0) && (wb_rd_addr == rs2_addr);

  // youngest producer wins
  assign rs1_val = rs1_hit_ex ? ex_fwd_data : (rs1_hit_wb ? wb_data : rs1_data);
  assign rs2_val = rs2_hit_ex ? ex_fwd_data : (rs2_hit_wb ? wb_data : rs2_data);

  assign op1        = rs1_val;
  assign op2        = op2_is_imm ? imm : rs2_val;
  assign store_data = rs2_val;

  // load data not ready until it leaves execute
  assign load_use_stall = ex_fwd_is_load && (rs1_hit_ex || rs2_hit_ex);

endmodule

`default_nettype wire

//--- design/ex_alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_alu import ex_pkg::*; (
  input  wire [`XLEN-1:0]  op1,
  input  wire [`XLEN-1:0]  op2,
  input  alu_op_e          alu_op,
  input  wire              is_word,
  output logic [`XLEN-1:0] alu_result,
  output logic [`CMP_W-1:0] cmp_flags
);

  logic [`XLEN-1:0]   res64;
  logic [`WORD_W-1:0] res32;
  logic [`WORD_W-1:0] a32;
  logic [`WORD_W-1:0] b32;
  logic [5:0]         sh64;
  logic [4:0]         sh32;
  logic               lt64;
  logic               ltu64;
  logic               lt32;
  logic               ltu32;

  assign a32  = op1[`WORD_W-1:0];
  assign b32  = op2[`WORD_W-1:0];
  assign sh64 = op2[5:0];
  assign sh32 = op2[4:0];

  assign lt64  = $signed(op1) < $signed(op2);
  assign ltu64 = op1 < op2;
  assign lt32  = $signed(a32) < $signed(b32);
  assign ltu32 = a32 < b32;

  // full width compare, branches never use word form
  assign cmp_flags[`CMP_EQ]  = (op1 == op2);
  assign cmp_flags[`CMP_LT]  = lt64;
  assign cmp_flags[`CMP_LTU] = ltu64;

  always_comb begin
    case (alu_op)
      ALU_ADD:      res64 = op1 + op2;
      ALU_SUB:      res64 = op1 - op2;
      ALU_SLL:      res64 = op1 << sh64;
      ALU_SLT:      res64 = {{(`XLEN-1){1'b0}}, lt64};
      ALU_SLTU:     res64 = {{(`XLEN-1){1'b0}}, ltu64};
      ALU_XOR:      res64 = op1 ^ op2;
      ALU_SRL:      res64 = op1 >> sh64;
      ALU_SRA:      res64 = $signed(op1) >>> sh64;
      ALU_OR:       res64 = op1 | op2;
      ALU_AND:      res64 = op1 & op2;
      ALU_LUI_PASS: res64 = op2;
      default:      res64 = '0;
    endcase
  end

  // word form on the low half
  always_comb begin
    case (alu_op)
      ALU_ADD:      res32 = a32 + b32;
      ALU_SUB:      res32 = a32 - b32;
      ALU_SLL:      res32 = a32 << sh32;
      ALU_SLT:      res32 = {{(`WORD_W-1){1'b0}}, lt32};
      ALU_SLTU:     res32 = {{(`WORD_W-1){1'b0}}, ltu32};
      ALU_XOR:      res32 = a32 ^ b32;
      ALU_SRL:      res32 = a32 >> sh32;
      ALU_SRA:      res32 = $signed(a32) >>> sh32;
      ALU_OR:       res32 = a32 | b32;
      ALU_AND:      res32 = a32 & b32;
      ALU_LUI_PASS: res32 = b32;
      default:      res32 = '0;
    endcase
  end

  assign alu_result = is_word ? {{(`XLEN-`WORD_W){res32[`WORD_W-1]}}, res32} : res64;

  // decode must never hand over an encoding outside the enum
  always_comb begin
    assert final ($isunknown(alu_op) || alu_op inside {[ALU_ADD:ALU_LUI_PASS]})
      else $error("ex_alu: illegal alu_op %0d", alu_op);
  end

endmodule

`default_nettype wire

//--- design/ex_branch.sv
// Branch and jump resolution
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_branch import ex_pkg::*; (
  input  bj_op_e            bj_op,
  input  wire [`CMP_W-1:0]  cmp_flags,
  input  wire [`XLEN-1:0]   pc,
  input  wire [`XLEN-1:0]   op1,
  input  wire [`XLEN-1:0]   jmp_imm,
  output logic              bj_taken,
  output logic [`XLEN-1:0]  target
);

  logic [`XLEN-1:0] pc_rel;
  logic [`XLEN-1:0] reg_rel;

  always_comb begin
    case (bj_op)
      BJ_BEQ:  bj_taken = cmp_flags[`CMP_EQ];
      BJ_BNE:  bj_taken = !cmp_flags[`CMP_EQ];
      BJ_BLT:  bj_taken = cmp_flags[`CMP_LT];
      BJ_BGE:  bj_taken = !cmp_flags[`CMP_LT];
      BJ_BLTU: bj_taken = cmp_flags[`CMP_LTU];
      BJ_BGEU: bj_taken = !cmp_flags[`CMP_LTU];
      BJ_JAL:  bj_taken = 1'b1;
      BJ_JALR: bj_taken = 1'b1;
      default: bj_taken = 1'b0;
    endcase
  end

  assign pc_rel  = pc + jmp_imm;
  assign reg_rel = op1 + jmp_imm;

  // jalr drops bit 0 of the sum
  assign target = (bj_op == BJ_JALR) ? {reg_rel[`XLEN-1:1], 1'b0} : pc_rel;

endmodule

`default_nettype wire

//--- design/ex_stage.sv
// Execute stage and EX/MEM register
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     id_valid,
  input  wire                     mem_allowin,
  input  wire                     load_use_stall,
  input  wire [`XLEN-1:0]         pc,
  input  wire [`INST_W-1:0]       inst,
  input  wire [`XLEN-1:0]         op1,
  input  wire [`XLEN-1:0]         op2,
  input  wire [`XLEN-1:0]         store_data,
  input  alu_op_e                 alu_op,
  input  wire                     is_word,
  input  bj_op_e                  bj_op,
  input  wire [`XLEN-1:0]         jmp_imm,
  input  mem_kind_e               mem_kind,
  input  wire                     mem_rd_ena_in,
  input  wire                     mem_wr_ena_in,
  input  wire                     rd_ena_in,
  input  wire [`REG_ADDR_W-1:0]   rd_addr_in,
  output logic                    id_allowin,
  output logic                    ex_mem_valid,
  output logic [`XLEN-1:0]        pc_out,
  output logic [`INST_W-1:0]      inst_out,
  output logic [`XLEN-1:0]        ex_data,
  output logic [`XLEN-1:0]        mem_wr_data,
  output mem_kind_e               mem_kind_out,
  output logic                    mem_rd_ena_out,
  output logic                    mem_wr_ena_out,
  output logic                    rd_ena_out,
  output logic [`REG_ADDR_W-1:0]  rd_addr_out,
  output logic                    bj_ena,
  output logic [`XLEN-1:0]        new_pc
);

  logic              ex_valid;
  logic              ex_allowin;
  logic              id_transfer;
  logic [`XLEN-1:0]  alu_result;
  logic [`CMP_W-1:0] cmp_flags;
  logic              bj_taken;
  logic [`XLEN-1:0]  result;
  logic              mem_rd_q;
  logic              mem_wr_q;
  logic              rd_ena_q;

  // single cycle stage ready whenever it is empty or draining
  assign ex_allowin   = !ex_valid || mem_allowin;
  assign id_allowin   = ex_allowin && !load_use_stall;
  assign id_transfer  = id_valid && id_allowin;
  assign ex_mem_valid = ex_valid;

  // a stalled load leaving execute leaves a bubble behind
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_transfer;
    end
  end

  ex_alu u_alu (
    .op1        (op1),
    .op2        (op2),
    .alu_op     (alu_op),
    .is_word    (is_word),
    .alu_result (alu_result),
    .cmp_flags  (cmp_flags)
  );

  ex_branch u_branch (
    .bj_op     (bj_op),
    .cmp_flags (cmp_flags),
    .pc        (pc),
    .op1       (op1),
    .jmp_imm   (jmp_imm),
    .bj_taken  (bj_taken),
    .target    (new_pc)
  );

  // link address for jal and jalr
  assign result = (bj_op == BJ_JAL || bj_op == BJ_JALR) ? pc + `XLEN'(`PC_STEP) : alu_result;
  assign bj_ena = id_transfer && bj_taken;

  always_ff @(posedge clk) begin
    if (id_transfer) begin
      pc_out       <= pc;
      inst_out     <= inst;
      ex_data      <= result;
      mem_wr_data  <= store_data;
      mem_kind_out <= mem_kind;
      mem_rd_q     <= mem_rd_ena_in;
      mem_wr_q     <= mem_wr_ena_in;
      rd_ena_q     <= rd_ena_in;
      rd_addr_out  <= rd_addr_in;
    end
  end

  // enables mean nothing without valid
  assign mem_rd_ena_out = ex_valid && mem_rd_q;
  assign mem_wr_ena_out = ex_valid && mem_wr_q;
  assign rd_ena_out     = ex_valid && rd_ena_q;

  hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
    ex_mem_valid && !mem_allowin |=> ex_mem_valid && $stable({pc_out, inst_out, ex_data,
      mem_wr_data, mem_kind_out, mem_rd_ena_out, mem_wr_ena_out, rd_ena_out, rd_addr_out}))
    else $error("ex_stage: EX/MEM register changed under back-pressure");

  // a redirect always belongs to an instruction that lands in the register
  redirect_with_transfer: assert property (@(posedge clk) disable iff (rst)
    bj_ena |=> ex_mem_valid && pc_out == $past(pc) && inst_out == $past(inst))
    else $error("ex_stage: bj_ena without a transfer");

endmodule

`default_nettype wire

//--- design/ex_subsystem.sv
// Execute subsystem top
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module ex_subsystem import ex_pkg::*; (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     id_valid,
  output logic                    id_allowin,
  input  wire [`XLEN-1:0]         pc,
  input  wire [`INST_W-1:0]       inst,
  input  wire [`REG_ADDR_W-1:0]   rs1_addr,
  input  wire [`REG_ADDR_W-1:0]   rs2_addr,
  input  wire [`XLEN-1:0]         rs1_data,
  input  wire [`XLEN-1:0]         rs2_data,
  input  wire [`XLEN-1:0]         imm,
  input  wire                     op2_is_imm,
  input  alu_op_e                 alu_op,
  input  wire                     is_word,
  input  bj_op_e                  bj_op,
  input  wire [`XLEN-1:0]         jmp_imm,
  input  mem_kind_e               mem_kind,
  input  wire                     mem_rd_ena_in,
  input  wire                     mem_wr_ena_in,
  input  wire                     rd_ena_in,
  input  wire [`REG_ADDR_W-1:0]   rd_addr_in,
  input  wire                     wb_rd_ena,
  input  wire [`REG_ADDR_W-1:0]   wb_rd_addr,
  input  wire [`XLEN-1:0]         wb_data,
  input  wire                     mem_allowin,
  output logic                    ex_mem_valid,
  output logic [`XLEN-1:0]        pc_out,
  output logic [`INST_W-1:0]      inst_out,
  output logic [`XLEN-1:0]        ex_data,
  output logic [`XLEN-1:0]        mem_wr_data,
  output mem_kind_e               mem_kind_out,
  output logic                    mem_rd_ena_out,
  output logic                    mem_wr_ena_out,
  output logic                    rd_ena_out,
  output logic [`REG_ADDR_W-1:0]  rd_addr_out,
  output logic                    bj_ena,
  output logic [`XLEN-1:0]        new_pc,
  output logic                    load_use_stall
);

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [`XLEN-1:0] store_data;

  // register outputs are already qualified by valid
  ex_forward u_forward (
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .imm            (imm),
    .op2_is_imm     (op2_is_imm),
    .ex_fwd_ena     (rd_ena_out),
    .ex_fwd_addr    (rd_addr_out),
    .ex_fwd_data    (ex_data),
    .ex_fwd_is_load (mem_rd_ena_out),
    .wb_rd_ena      (wb_rd_ena),
    .wb_rd_addr     (wb_rd_addr),
    .wb_data        (wb_data),
    .op1            (op1),
    .op2            (op2),
    .store_data     (store_data),
    .load_use_stall (load_use_stall)
  );

  ex_stage u_stage (
    .clk            (clk),
    .rst            (rst),
    .id_valid       (id_valid),
    .mem_allowin    (mem_allowin),
    .load_use_stall (load_use_stall),
    .pc             (pc),
    .inst           (inst),
    .op1            (op1),
    .op2            (op2),
    .store_data     (store_data),
    .alu_op         (alu_op),
    .is_word        (is_word),
    .bj_op          (bj_op),
    .jmp_imm        (jmp_imm),
    .mem_kind       (mem_kind),
    .mem_rd_ena_in  (mem_rd_ena_in),
    .mem_wr_ena_in  (mem_wr_ena_in),
    .rd_ena_in      (rd_ena_in),
    .rd_addr_in     (rd_addr_in),
    .id_allowin     (id_allowin),
    .ex_mem_valid   (ex_mem_valid),
    .pc_out         (pc_out),
    .inst_out       (inst_out),
    .ex_data        (ex_data),
    .mem_wr_data    (mem_wr_data),
    .mem_kind_out   (mem_kind_out),
    .mem_rd_ena_out (mem_rd_ena_out),
    .mem_wr_ena_out (mem_wr_ena_out),
    .rd_ena_out     (rd_ena_out),
    .rd_addr_out    (rd_addr_out),
    .bj_ena         (bj_ena),
    .new_pc         (new_pc)
  );

endmodule

`default_nettype wire

//--- tests/tb_ex_subsystem.sv
// Execute subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "ex_cfg.svh"

module tb_ex_subsystem import ex_pkg::*; ();

  localparam int ROW_LIMIT = 16;

  typedef struct packed {
    alu_op_e                op;
    logic                   w;
    bj_op_e                 bj;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   rd_en;
    logic                   ld;
    logic                   isel;
    logic [`XLEN-1:0]       v1;
    logic [`XLEN-1:0]       v2;
    logic [`XLEN-1:0]       imm;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_a;
    logic [`XLEN-1:0]       wb_v;
    logic [3:0]             bp;
  } row_t;

  logic clk;
  logic rst;
  logic id_valid;
  logic id_allowin;
  logic [`XLEN-1:0] pc;
  logic [`INST_W-1:0] inst;
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] imm;
  logic op2_is_imm;
  alu_op_e alu_op;
  logic is_word;
  bj_op_e bj_op;
  logic [`XLEN-1:0] jmp_imm;
  mem_kind_e mem_kind;
  logic mem_rd_ena_in;
  logic mem_wr_ena_in;
  logic rd_ena_in;
  logic [`REG_ADDR_W-1:0] rd_addr_in;
  logic wb_rd_ena;
  logic [`REG_ADDR_W-1:0] wb_rd_addr;
  logic [`XLEN-1:0] wb_data;
  logic mem_allowin;
  logic ex_mem_valid;
  logic [`XLEN-1:0] pc_out;
  logic [`INST_W-1:0] inst_out;
  logic [`XLEN-1:0] ex_data;
  logic [`XLEN-1:0] mem_wr_data;
  mem_kind_e mem_kind_out;
  logic mem_rd_ena_out;
  logic mem_wr_ena_out;
  logic rd_ena_out;
  logic [`REG_ADDR_W-1:0] rd_addr_out;
  logic bj_ena;
  logic [`XLEN-1:0] new_pc;
  logic load_use_stall;

  // expected content of the EX/MEM register
  logic                   m_valid;
  logic                   m_rd_en;
  logic                   m_ld;
  logic                   m_wr;
  logic [`REG_ADDR_W-1:0] m_rd;
  logic [`XLEN-1:0]       m_data;
  logic [`XLEN-1:0]       m_pc;
  logic [`INST_W-1:0]     m_inst;
  logic [`XLEN-1:0]       m_wdata;
  mem_kind_e              m_kind;

  row_t rows[$];
  int   error_count;
  int   check_count;
  int   retired;

  // shift by 31 in both forms and then by 33 and 1
  logic [`XLEN-1:0] alu_a [2] = '{64'h8000_0001_7fff_ff85, 64'h0000_0000_ffff_fff0};
  logic [`XLEN-1:0] alu_b [2] = '{64'hffff_ffff_8000_001f, 64'h0000_0000_0000_0021};
  logic [3:0]       alu_bp [2] = '{4'b1111, 4'b1110};
  logic [`XLEN-1:0] br_a [2] = '{64'd5, 64'hffff_ffff_ffff_fffd};
  logic [`XLEN-1:0] br_b [2] = '{64'd5, 64'd4};
  logic [`XLEN-1:0] br_imm [2] = '{64'h20, 64'hffff_ffff_ffff_fff0};

  ex_subsystem dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [`XLEN-1:0] got,
      input logic [`XLEN-1:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [`XLEN-1:0] alu_model(input alu_op_e op, input logic w,
      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    logic [31:0]      aw;
    logic [31:0]      bw;
    logic [31:0]      r32;
    logic [`XLEN-1:0] r;
    aw = a[31:0];
    bw = b[31:0];
    r = '0;
    r32 = '0;
    case (op)
      ALU_ADD:  r = w ? a[31:0] + b[31:0] : a + b;
      ALU_SUB:  r = w ? aw - bw : a - b;
      ALU_SLL:  r = w ? aw << b[4:0] : a << b[5:0];
      ALU_SLT:  r = w ? ($signed(aw) < $signed(bw)) : ($signed(a) < $signed(b));
      ALU_SLTU: r = w ? (aw < bw) : (a < b);
      ALU_XOR:  r = a ^ b;
      ALU_SRL:  r = w ? aw >> b[4:0] : a >> b[5:0];
      ALU_SRA: begin
        // sign fill from an extended copy
        if (w) begin
          r = {{32{aw[31]}}, aw} >> b[4:0];
        end else begin
          r = a >> b[5:0];
          if (a[63])
            r = r | ~({64{1'b1}} >> b[5:0]);
        end
      end
      ALU_OR:   r = a | b;
      ALU_AND:  r = a & b;
      default:  r = b;
    endcase
    r32 = r[31:0];
    if (w)
      r = {{32{r32[31]}}, r32};
    return r;
  endfunction

  function automatic logic branch_taken(input bj_op_e bj, input logic [`XLEN-1:0] a,
      input logic [`XLEN-1:0] b);
    case (bj)
      BJ_BEQ:  return a == b;
      BJ_BNE:  return a != b;
      BJ_BLT:  return $signed(a) < $signed(b);
      BJ_BGE:  return $signed(a) >= $signed(b);
      BJ_BLTU: return a < b;
      BJ_BGEU: return a >= b;
      BJ_JAL:  return 1'b1;
      BJ_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // execute register has priority over writeback
  function automatic logic [`XLEN-1:0] bypassed(input logic [`REG_ADDR_W-1:0] addr,
      input logic [`XLEN-1:0] rf_val, input row_t r);
    logic [`XLEN-1:0] v;
    v = rf_val;
    if (addr != '0 && r.wb_en && r.wb_a == addr)
      v = r.wb_v;
    if (addr != '0 && m_valid && m_rd_en && m_rd == addr)
      v = m_data;
    return v;
  endfunction

  task automatic alu_entry(input alu_op_e op, input logic w, input logic [`XLEN-1:0] a,
      input logic [`XLEN-1:0] b, input logic [3:0] bp);
    row_t r;
    r = '0;
    r.op = op;
    r.w = w;
    r.bj = BJ_NONE;
    r.rs1 = 5'd1;
    r.rs2 = 5'd2;
    r.rd = 5'd3;
    r.rd_en = 1'b1;
    r.v1 = a;
    r.v2 = b;
    r.bp = bp;
    rows.push_back(r);
  endtask

  task automatic branch_entry(input bj_op_e bj, input logic [`XLEN-1:0] a,
      input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] offs);
    row_t r;
    r = '0;
    r.op = ALU_SUB;
    r.bj = bj;
    r.rs1 = 5'd1;
    r.rs2 = 5'd2;
    r.rd = 5'd3;
    r.rd_en = (bj == BJ_JAL || bj == BJ_JALR);
    r.v1 = a;
    r.v2 = b;
    r.imm = offs;
    r.bp = 4'b1111;
    rows.push_back(r);
  endtask

  task automatic bypass_entry(input int rs1, input int rs2, input int rd, input logic ld,
      input logic wb_en, input int wb_a, input logic [`XLEN-1:0] wb_v);
    row_t r;
    r = '0;
    r.op = ALU_ADD;
    r.bj = BJ_NONE;
    r.rs1 = 5'(rs1);
    r.rs2 = 5'(rs2);
    r.rd = 5'(rd);
    r.rd_en = 1'b1;
    r.ld = ld;
    r.v1 = (rs1 == 0) ? '0 : 64'h1111_0000_0000_0101;
    r.v2 = (rs2 == 0) ? '0 : 64'h0000_2222_0000_0002;
    r.wb_en = wb_en;
    r.wb_a = 5'(wb_a);
    r.wb_v = wb_v;
    r.bp = 4'b1111;
    rows.push_back(r);
  endtask

  task automatic random_entry();
    row_t r;
    r = '0;
    r.op = alu_op_e'($urandom_range(0, 10));
    r.w = 1'($urandom_range(0, 1));
    r.bj = bj_op_e'($urandom_range(0, 8));
    r.rs1 = 5'($urandom_range(0, 3));
    r.rs2 = 5'($urandom_range(0, 3));
    r.rd = 5'($urandom_range(0, 3));
    r.rd_en = 1'b1;
    r.ld = ($urandom_range(0, 3) == 0);
    r.isel = 1'($urandom_range(0, 1));
    r.v1 = {$urandom, $urandom};
    r.v2 = {$urandom, $urandom};
    r.imm = {$urandom, $urandom};
    r.wb_en = 1'($urandom_range(0, 1));
    r.wb_a = 5'($urandom_range(0, 3));
    r.wb_v = {$urandom, $urandom};
    // at least one free slot in four
    r.bp = 4'($urandom) | 4'b0001;
    rows.push_back(r);
  endtask

  task automatic drive_row(input row_t r, input int idx, input int cyc);
    id_valid = 1'b1;
    pc = 64'h1000 + 64'(idx) * 4;
    inst = 32'(idx) ^ 32'h0000_0013;
    rs1_addr = r.rs1;
    rs2_addr = r.rs2;
    rs1_data = r.v1;
    rs2_data = r.v2;
    imm = r.imm;
    op2_is_imm = r.isel;
    alu_op = r.op;
    is_word = r.w;
    bj_op = r.bj;
    jmp_imm = r.imm;
    mem_kind = mem_kind_e'(idx[2:0]);
    mem_rd_ena_in = r.ld;
    mem_wr_ena_in = !r.ld && (idx % 3 == 0);
    rd_ena_in = r.rd_en;
    rd_addr_in = r.rd;
    wb_rd_ena = r.wb_en;
    wb_rd_addr = r.wb_a;
    wb_data = r.wb_v;
    mem_allowin = r.bp[cyc % 4];
  endtask

  task automatic check_register();
    check_value("ex_mem_valid", ex_mem_valid, m_valid);
    if (m_valid) begin
      check_value("ex_data", ex_data, m_data);
      check_value("pc_out", pc_out, m_pc);
      check_value("inst_out", inst_out, m_inst);
      check_value("mem_wr_data", mem_wr_data, m_wdata);
      check_value("mem_kind_out", mem_kind_out, m_kind);
      check_value("rd_addr_out", rd_addr_out, m_rd);
      check_value("rd/mem enables", {mem_rd_ena_out, mem_wr_ena_out, rd_ena_out},
                  {m_ld, m_wr, m_rd_en});
    end
    if (ex_mem_valid && mem_allowin)
      retired++;
  endtask

  initial begin
    row_t             r;
    int               idx;
    int               cyc;
    logic             timed_out;
    logic [`XLEN-1:0] op1e;
    logic [`XLEN-1:0] rs2e;
    logic [`XLEN-1:0] op2e;
    logic [`XLEN-1:0] exp_data;
    logic [`XLEN-1:0] target;
    logic             stall_e;
    logic             xfer;
    logic             taken;
    rst = 1'b1;
    id_valid = 1'b0;
    pc = '0;
    inst = '0;
    rs1_addr = '0;
    rs2_addr = '0;
    rs1_data = '0;
    rs2_data = '0;
    imm = '0;
    op2_is_imm = 1'b0;
    alu_op = ALU_ADD;
    is_word = 1'b0;
    bj_op = BJ_JAL;
    jmp_imm = '0;
    mem_kind = MEM_B;
    mem_rd_ena_in = 1'b0;
    mem_wr_ena_in = 1'b0;
    rd_ena_in = 1'b0;
    rd_addr_in = '0;
    wb_rd_ena = 1'b0;
    wb_rd_addr = '0;
    wb_data = '0;
    mem_allowin = 1'b1;
    m_valid = 1'b0;
    error_count = 0;
    check_count = 0;
    retired = 0;
    timed_out = 1'b0;
    void'($urandom(32'h3ef3));

    for (int p = 0; p < 2; p++)
      for (int k = 0; k <= int'(ALU_LUI_PASS); k++)
        for (int w = 0; w < 2; w++)
          alu_entry(alu_op_e'(k), 1'(w), alu_a[p], alu_b[p], alu_bp[p]);
    for (int k = 0; k <= int'(BJ_JALR); k++)
      for (int p = 0; p < 2; p++)
        branch_entry(bj_op_e'(k), br_a[p], br_b[p], br_imm[p]);
    bypass_entry(1, 2, 7, 1'b0, 1'b0, 0, '0);
    // x7 pending in execute and in writeback
    bypass_entry(7, 2, 0, 1'b0, 1'b1, 7, 64'hdead_beef_0000_0007);
    bypass_entry(0, 0, 10, 1'b0, 1'b1, 0, 64'h0bad_0bad_0bad_0bad);
    bypass_entry(3, 9, 4, 1'b0, 1'b1, 9, 64'h0000_0000_0000_0077);
    bypass_entry(1, 2, 5, 1'b1, 1'b0, 0, '0);
    bypass_entry(5, 2, 6, 1'b0, 1'b0, 0, '0);
    for (int k = 0; k < 40; k++)
      random_entry();

    for (int k = 0; k < 4; k++)
      @(posedge clk);
    #2 rst = 1'b0;
    @(negedge clk);
    // a jump sits on the inputs while id_valid is low
    check_value("ex_mem_valid after reset", ex_mem_valid, 1'b0);
    check_value("bj_ena after reset", bj_ena, 1'b0);
    @(posedge clk);
    #2;

    idx = 0;
    cyc = 0;
    while (idx < rows.size() && !timed_out) begin
      r = rows[idx];
      drive_row(r, idx, cyc);
      @(negedge clk);
      op1e = bypassed(r.rs1, r.v1, r);
      rs2e = bypassed(r.rs2, r.v2, r);
      op2e = r.isel ? r.imm : rs2e;
      stall_e = m_valid && m_ld && m_rd_en &&
                ((r.rs1 != '0 && r.rs1 == m_rd) || (r.rs2 != '0 && r.rs2 == m_rd));
      xfer = (!m_valid || mem_allowin) && !stall_e;
      taken = branch_taken(r.bj, op1e, op2e);
      target = (r.bj == BJ_JALR) ? ((op1e + r.imm) & ~64'd1) : pc + r.imm;
      if (r.bj == BJ_JAL || r.bj == BJ_JALR)
        exp_data = pc + 64'd4;
      else
        exp_data = alu_model(r.op, r.w, op1e, op2e);
      check_value("load_use_stall", load_use_stall, stall_e);
      check_value("id_allowin", id_allowin, xfer);
      check_value("bj_ena", bj_ena, xfer && taken);
      if (xfer && taken)
        check_value("new_pc", new_pc, target);
      check_register();
      @(posedge clk);
      if (!m_valid || mem_allowin) begin
        m_valid = xfer;
        if (xfer) begin
          m_rd_en = r.rd_en;
          m_ld = r.ld;
          m_wr = mem_wr_ena_in;
          m_rd = r.rd;
          m_data = exp_data;
          m_pc = pc;
          m_inst = inst;
          m_wdata = rs2e;
          m_kind = mem_kind;
        end
      end
      if (xfer) begin
        idx++;
        cyc = 0;
      end else begin
        cyc++;
      end
      if (cyc > ROW_LIMIT) begin
        timed_out = 1'b1;
        $display("timeout: row %0d was not accepted within %0d cycles", idx, ROW_LIMIT);
      end
      #2;
    end

    if (!timed_out) begin
      id_valid = 1'b0;
      mem_allowin = 1'b1;
      cyc = 0;
      while (m_valid && cyc < 8) begin
        @(negedge clk);
        check_register();
        @(posedge clk);
        m_valid = 1'b0;
        cyc++;
        #2;
      end
      check_value("retired instructions", retired, rows.size());
    end

    $display("checks: %0d, errors: %0d, retired: %0d of %0d rows",
             check_count, error_count, retired, rows.size());
    if (error_count == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ex_subsystem.f
+incdir+design
design/ex_pkg.sv
design/ex_forward.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_stage.sv
design/ex_subsystem.sv
tests/tb_ex_subsystem.sv

//--- Bender.yml
package:
  name: ex_subsystem

sources:
  - include_dirs:
      - design
    files:
      - design/ex_pkg.sv
      - design/ex_forward.sv
      - design/ex_alu.sv
      - design/ex_branch.sv
      - design/ex_stage.sv
      - design/ex_subsystem.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_ex_subsystem.sv
